/* core_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// core wrapper shared definitions
// bridge map, controller key layout, console button order,
// synchronizer depth and the scaler video word
////////////////////////////////////////////////////////////////////////////

package core_pkg;

  //////////////////////////////////////////////////////////////////////////
  // bridge bus

  localparam int unsigned bridge_addr_w = 32;
  localparam int unsigned bridge_data_w = 32;

  // settings registers, one bit each
  localparam logic [bridge_addr_w-1:0] addr_download = 32'h0000_0000;
  localparam logic [bridge_addr_w-1:0] addr_sgx      = 32'h0000_0004;
  localparam logic [bridge_addr_w-1:0] addr_overscan = 32'h0000_0100;
  localparam logic [bridge_addr_w-1:0] addr_border   = 32'h0000_0104;

  //////////////////////////////////////////////////////////////////////////
  // controller

  localparam int unsigned key_w = 16;

  // bit positions in the host key bitmap
  localparam int unsigned key_up     = 0;
  localparam int unsigned key_down   = 1;
  localparam int unsigned key_left   = 2;
  localparam int unsigned key_right  = 3;
  localparam int unsigned key_a      = 4;
  localparam int unsigned key_b      = 5;
  localparam int unsigned key_select = 14;
  localparam int unsigned key_start  = 15;

  // console button vector, in console order
  localparam int unsigned btn_w      = 8;
  localparam int unsigned btn_up     = 0;
  localparam int unsigned btn_down   = 1;
  localparam int unsigned btn_left   = 2;
  localparam int unsigned btn_right  = 3;
  localparam int unsigned btn_a      = 4;
  localparam int unsigned btn_b      = 5;
  localparam int unsigned btn_select = 6;
  localparam int unsigned btn_start  = 7;

  // flop stages on the async key input
  localparam int unsigned sync_stages = 3;

  //////////////////////////////////////////////////////////////////////////
  // video

  // hsync pushed this many strobes past its edge
  localparam int unsigned hs_delay_load = 2;

  localparam int unsigned rgb_w  = 24;
  localparam int unsigned slot_w = 2;

  // one scaler word, read as colour while active
  // or as the end-of-line slot code on the first blank pixel
  typedef union packed {
    struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
    } pixel;
    struct packed {
      logic [8:0]        pad;
      logic [slot_w-1:0] slot;
      logic [12:0]       rsvd;
    } eol;
  } video_word_t;

endpackage

/* bridge_settings_regs.sv */
////////////////////////////////////////////////////////////////////////////
// bridge settings register bank
// four single-bit settings, written on the bridge strobe and read back
// at their own addresses through a combinational mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bridge_settings_regs (
  input  logic                               clk_74a,
  input  logic                               arst_n,
  input  logic [core_pkg::bridge_addr_w-1:0] bridge_addr,
  input  logic                               bridge_wr,
  input  logic [core_pkg::bridge_data_w-1:0] bridge_wr_data,
  output logic [core_pkg::bridge_data_w-1:0] bridge_rd_data,
  output logic                               cart_download,
  output logic                               sgx_mode,
  output logic                               overscan_enable,
  output logic                               border_enable
);

  //////////////////////////////////////////////////////////////////////////
  // write decode

  // only bit 0 of the data word is kept
  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      cart_download   <= 1'b0;
      sgx_mode        <= 1'b0;
      overscan_enable <= 1'b0;
      border_enable   <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        core_pkg::addr_download: begin
          cart_download <= bridge_wr_data[0];
        end
        core_pkg::addr_sgx: begin
          sgx_mode <= bridge_wr_data[0];
        end
        core_pkg::addr_overscan: begin
          overscan_enable <= bridge_wr_data[0];
        end
        core_pkg::addr_border: begin
          border_enable <= bridge_wr_data[0];
        end
        default: begin
          // unmapped, dropped
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // readback

  // setting in bit 0, upper bits zero
  // anything outside the four addresses reads as zero
  always_comb begin
    bridge_rd_data = '0;
    case (bridge_addr)
      core_pkg::addr_download: begin
        bridge_rd_data[0] = cart_download;
      end
      core_pkg::addr_sgx: begin
        bridge_rd_data[0] = sgx_mode;
      end
      core_pkg::addr_overscan: begin
        bridge_rd_data[0] = overscan_enable;
      end
      core_pkg::addr_border: begin
        bridge_rd_data[0] = border_enable;
      end
      default: begin
        bridge_rd_data = '0;
      end
    endcase
  end

endmodule

/* pad_key_sync.sv */
////////////////////////////////////////////////////////////////////////////
// player one key synchronizer
// brings the async key bitmap onto clk_74a and picks the console buttons
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pad_key_sync (
  input  logic                       clk_74a,
  input  logic                       arst_n,
  input  logic [core_pkg::key_w-1:0] cont1_key,
  output logic [core_pkg::btn_w-1:0] pad_buttons
);

  // stage 0 takes the raw input, last stage feeds the remap
  logic [core_pkg::sync_stages-1:0][core_pkg::key_w-1:0] key_q;
  logic [core_pkg::key_w-1:0]                            key_s;

  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      key_q <= '0;
    end else begin
      key_q <= {key_q[core_pkg::sync_stages-2:0], cont1_key};
    end
  end

  assign key_s = key_q[core_pkg::sync_stages-1];

  // console order, unused triggers and face x/y dropped
  always_comb begin
    pad_buttons                       = '0;
    pad_buttons[core_pkg::btn_up]     = key_s[core_pkg::key_up];
    pad_buttons[core_pkg::btn_down]   = key_s[core_pkg::key_down];
    pad_buttons[core_pkg::btn_left]   = key_s[core_pkg::key_left];
    pad_buttons[core_pkg::btn_right]  = key_s[core_pkg::key_right];
    pad_buttons[core_pkg::btn_a]      = key_s[core_pkg::key_a];
    pad_buttons[core_pkg::btn_b]      = key_s[core_pkg::key_b];
    pad_buttons[core_pkg::btn_select] = key_s[core_pkg::key_select];
    pad_buttons[core_pkg::btn_start]  = key_s[core_pkg::key_start];
  end

endmodule

/* video_out_conditioner.sv */
////////////////////////////////////////////////////////////////////////////
// video output conditioner
// turns core blanks and syncs into scaler timing: data enable, colour,
// end-of-line slot word, one-pixel vsync and a delayed one-pixel hsync
// everything advances only on the pixel strobe pix_ce
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_out_conditioner (
  input  logic                       clk_74a,
  input  logic                       arst_n,
  input  logic                       pix_ce,
  input  logic                       hblank,
  input  logic                       vblank,
  input  logic                       hsync,
  input  logic                       vsync,
  input  logic [core_pkg::rgb_w-1:0] pix_rgb,
  input  logic [1:0]                 dotclock_divider,
  output logic [core_pkg::rgb_w-1:0] video_rgb,
  output logic                       video_de,
  output logic                       video_hs,
  output logic                       video_vs
);

  // active pixel from the core
  logic                         de;

  // scaler slot for the current dot clock
  logic [core_pkg::slot_w-1:0]  slot;
  core_pkg::video_word_t        eol_word;

  // registered output word
  core_pkg::video_word_t        rgb_q;

  // previous strobe history, for edge detect
  logic                         de_prev;
  logic                         hs_prev;
  logic                         vs_prev;

  // counts strobes down to the hsync pulse
  logic [1:0]                   hs_delay;

  assign de = ~(hblank | vblank);

  //////////////////////////////////////////////////////////////////////////
  // end-of-line word

  // divider 0 and 1 map straight through
  // 2 and 3 share the fastest slot
  always_comb begin
    if (dotclock_divider[1]) begin
      slot = 2'd2;
    end else begin
      slot = dotclock_divider;
    end
  end

  // zero pad, slot, zero reserved bits
  always_comb begin
    eol_word          = '0;
    eol_word.eol.slot = slot;
  end

  //////////////////////////////////////////////////////////////////////////
  // per-strobe registers

  always_ff @(posedge clk_74a or negedge arst_n) begin
    if (!arst_n) begin
      rgb_q    <= '0;
      video_de <= 1'b0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      de_prev  <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
    end else if (pix_ce) begin
      video_de <= de;

      // colour while active, slot word on the first blank pixel
      if (de) begin
        rgb_q <= core_pkg::video_word_t'(pix_rgb);
      end else if (de_prev) begin
        rgb_q <= eol_word;
      end else begin
        rgb_q <= '0;
      end

      // one strobe wide on the vsync rising edge
      video_vs <= vsync & ~vs_prev;

      // hsync fires as the counter passes 1
      video_hs <= (hs_delay == 2'd1);

      // a fresh edge reloads, else run down to zero
      if (hsync & ~hs_prev) begin
        hs_delay <= 2'(core_pkg::hs_delay_load);
      end else if (hs_delay != 2'd0) begin
        hs_delay <= hs_delay - 2'd1;
      end

      de_prev <= de;
      hs_prev <= hsync;
      vs_prev <= vsync;
    end
  end

  assign video_rgb = rgb_q;

endmodule

/* core_top.sv */
////////////////////////////////////////////////////////////////////////////
// user core wrapper top
// bridge settings bank, player one key sync and video conditioner,
// all on clk_74a
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_top (
  input  logic                               clk_74a,
  input  logic                               arst_n,

  // bridge, synchronous to clk_74a
  input  logic [core_pkg::bridge_addr_w-1:0] bridge_addr,
  input  logic                               bridge_wr,
  input  logic [core_pkg::bridge_data_w-1:0] bridge_wr_data,
  output logic [core_pkg::bridge_data_w-1:0] bridge_rd_data,

  // settings to the console core
  output logic                               cart_download,
  output logic                               sgx_mode,
  output logic                               overscan_enable,
  output logic                               border_enable,

  // controller, async
  input  logic [core_pkg::key_w-1:0]         cont1_key,
  output logic [core_pkg::btn_w-1:0]         pad_buttons,

  // video from the console core
  input  logic                               pix_ce,
  input  logic                               hblank,
  input  logic                               vblank,
  input  logic                               hsync,
  input  logic                               vsync,
  input  logic [core_pkg::rgb_w-1:0]         pix_rgb,
  input  logic [1:0]                         dotclock_divider,

  // video to the scaler
  output logic [core_pkg::rgb_w-1:0]         video_rgb,
  output logic                               video_de,
  output logic                               video_hs,
  output logic                               video_vs
);

  // settings bank, written and read back over the bridge
  bridge_settings_regs u_settings (
    .clk_74a         (clk_74a),
    .arst_n          (arst_n),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .bridge_rd_data  (bridge_rd_data),
    .cart_download   (cart_download),
    .sgx_mode        (sgx_mode),
    .overscan_enable (overscan_enable),
    .border_enable   (border_enable)
  );

  // player one pad
  pad_key_sync u_pad (
    .clk_74a     (clk_74a),
    .arst_n      (arst_n),
    .cont1_key   (cont1_key),
    .pad_buttons (pad_buttons)
  );

  // scaler video timing
  video_out_conditioner u_video (
    .clk_74a          (clk_74a),
    .arst_n           (arst_n),
    .pix_ce           (pix_ce),
    .hblank           (hblank),
    .vblank           (vblank),
    .hsync            (hsync),
    .vsync            (vsync),
    .pix_rgb          (pix_rgb),
    .dotclock_divider (dotclock_divider),
    .video_rgb        (video_rgb),
    .video_de         (video_de),
    .video_hs         (video_hs),
    .video_vs         (video_vs)
  );

endmodule

/* tb_checks.svh */
////////////////////////////////////////////////////////////////////////////
// testbench compare tasks
// one compare per kind of DUT result, error reporting and the
// xorshift generator for random pixel steps
////////////////////////////////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// prints the mismatch and stops the run
task automatic report_error(input string msg);
  $display("ERROR at %0t: %s", $time, msg);
  $display("Test failed");
  $fatal(1);
endtask

// bridge readback word
task automatic check_rd_data(input logic [core_pkg::bridge_data_w-1:0] got,
                             input logic [core_pkg::bridge_data_w-1:0] exp,
                             input logic [core_pkg::bridge_addr_w-1:0] addr);
  if (got !== exp) begin
    report_error($sformatf("read at %08h gave %08h, expected %08h", addr, got, exp));
  end
endtask

// settings levels packed as {border, overscan, sgx, download}
task automatic check_settings(input logic [3:0] got, input logic [3:0] exp);
  if (got !== exp) begin
    report_error($sformatf("settings outputs %04b, expected %04b", got, exp));
  end
endtask

// console button vector
task automatic check_buttons(input logic [core_pkg::btn_w-1:0] got,
                             input logic [core_pkg::btn_w-1:0] exp);
  if (got !== exp) begin
    report_error($sformatf("pad_buttons %02h, expected %02h", got, exp));
  end
endtask

// video word plus de, hs and vs
task automatic check_video(input core_pkg::video_word_t got, input logic got_de,
                           input logic got_hs, input logic got_vs,
                           input core_pkg::video_word_t exp, input logic exp_de,
                           input logic exp_hs, input logic exp_vs);
  if (got !== exp || got_de !== exp_de || got_hs !== exp_hs || got_vs !== exp_vs) begin
    report_error($sformatf("video rgb %06h de %b hs %b vs %b, expected %06h %b %b %b",
                           got, got_de, got_hs, got_vs, exp, exp_de, exp_hs, exp_vs));
  end
endtask

// 32-bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] xorshift_next(input logic [31:0] x);
  logic [31:0] s;
  s = x ^ (x << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

`endif

/* tb_core_top.sv */
////////////////////////////////////////////////////////////////////////////
// core wrapper testbench
// replays records from core_testdata.txt against the DUT and checks
// the video path against a per-strobe reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_core_top;

  localparam int max_records = 64;

  logic                               clk_74a;
  logic                               arst_n;
  logic [core_pkg::bridge_addr_w-1:0] bridge_addr;
  logic                               bridge_wr;
  logic [core_pkg::bridge_data_w-1:0] bridge_wr_data;
  logic [core_pkg::bridge_data_w-1:0] bridge_rd_data;
  logic                               cart_download;
  logic                               sgx_mode;
  logic                               overscan_enable;
  logic                               border_enable;
  logic [core_pkg::key_w-1:0]         cont1_key;
  logic [core_pkg::btn_w-1:0]         pad_buttons;
  logic                               pix_ce;
  logic                               hblank;
  logic                               vblank;
  logic                               hsync;
  logic                               vsync;
  logic [core_pkg::rgb_w-1:0]         pix_rgb;
  logic [1:0]                         dotclock_divider;
  logic [core_pkg::rgb_w-1:0]         video_rgb;
  logic                               video_de;
  logic                               video_hs;
  logic                               video_vs;

  // parsed records as a kind letter plus up to six hex fields
  logic [7:0]  rec_kind [max_records];
  logic [31:0] rec_f [max_records][6];
  int          n_rec = 0;
  int          rand_steps = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [31:0] rand_state = 32'h30c05415;

  // expected values
  logic [3:0]                 exp_settings = '0;
  logic [core_pkg::btn_w-1:0] exp_buttons = '0;
  core_pkg::video_word_t      exp_rgb = '0;
  logic                       exp_de = 1'b0;
  logic                       exp_hs = 1'b0;
  logic                       exp_vs = 1'b0;

  // model history of the last strobe and hsync edges one and two strobes back
  logic m_de_prev = 1'b0;
  logic m_hs_prev = 1'b0;
  logic m_vs_prev = 1'b0;
  logic m_edge1 = 1'b0;
  logic m_edge2 = 1'b0;

  `include "tb_checks.svh"

  core_top DUT (.*);

  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  // hang guard
  always @(posedge clk_74a) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("the run hung, still going after %0d clock cycles", cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // reference model called once per pixel strobe

  task automatic model_strobe();
    logic de;
    de = !(hblank || vblank);
    exp_de = de;
    exp_vs = vsync && !m_vs_prev;
    // hs shows the edge seen two strobes ago
    exp_hs = m_edge2;
    m_edge2 = m_edge1;
    m_edge1 = hsync && !m_hs_prev;
    if (de) begin
      exp_rgb = pix_rgb;
    end else begin
      exp_rgb = '0;
      // first blank strobe carries the slot code
      if (m_de_prev) begin
        case (dotclock_divider)
          2'd0: exp_rgb.eol.slot = 2'd0;
          2'd1: exp_rgb.eol.slot = 2'd1;
          default: exp_rgb.eol.slot = 2'd2;
        endcase
      end
    end
    m_de_prev = de;
    m_hs_prev = hsync;
    m_vs_prev = vsync;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // stimulus steps entered and left on a falling edge

  task automatic pixel_step(input logic ce, input logic hb, input logic vb,
                            input logic hs, input logic vs,
                            input logic [core_pkg::rgb_w-1:0] rgb, input logic [1:0] div);
    pix_ce = ce;
    hblank = hb;
    vblank = vb;
    hsync = hs;
    vsync = vs;
    pix_rgb = rgb;
    dotclock_divider = div;
    // model holds like the outputs when there is no strobe
    if (ce) begin
      model_strobe();
    end
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_video(video_rgb, video_de, video_hs, video_vs, exp_rgb, exp_de, exp_hs, exp_vs);
  endtask

  task automatic bridge_write(input logic [core_pkg::bridge_addr_w-1:0] addr,
                              input logic [core_pkg::bridge_data_w-1:0] data);
    bridge_addr = addr;
    bridge_wr_data = data;
    bridge_wr = 1'b1;
    pix_ce = 1'b0;
    // nothing moves before the edge
    check_settings({border_enable, overscan_enable, sgx_mode, cart_download}, exp_settings);
    case (addr)
      32'h0000_0000: exp_settings[0] = data[0];
      32'h0000_0004: exp_settings[1] = data[0];
      32'h0000_0100: exp_settings[2] = data[0];
      32'h0000_0104: exp_settings[3] = data[0];
      default: begin
      end
    endcase
    @(posedge clk_74a);
    @(negedge clk_74a);
    bridge_wr = 1'b0;
    check_settings({border_enable, overscan_enable, sgx_mode, cart_download}, exp_settings);
  endtask

  task automatic bridge_read(input logic [core_pkg::bridge_addr_w-1:0] addr,
                             input logic [core_pkg::bridge_data_w-1:0] exp);
    bridge_addr = addr;
    pix_ce = 1'b0;
    @(posedge clk_74a);
    @(negedge clk_74a);
    check_rd_data(bridge_rd_data, exp, addr);
  endtask

  // old buttons for two clocks, new ones on the third
  task automatic key_step(input logic [core_pkg::key_w-1:0] keys,
                          input logic [core_pkg::btn_w-1:0] btns);
    int i;
    cont1_key = keys;
    pix_ce = 1'b0;
    for (i = 1; i <= 3; i++) begin
      @(posedge clk_74a);
      @(negedge clk_74a);
      if (i == 3) begin
        exp_buttons = btns;
      end
      check_buttons(pad_buttons, exp_buttons);
    end
  endtask

  // random strobe placement with random blanks, syncs and colour
  task automatic random_steps(input int n);
    int i;
    logic [31:0] a;
    logic [31:0] b;
    for (i = 0; i < n; i++) begin
      rand_state = xorshift_next(rand_state);
      a = rand_state;
      rand_state = xorshift_next(rand_state);
      b = rand_state;
      pixel_step(a[1:0] != 2'b00, a[8], a[11:9] == 3'd0, a[12], a[13], b[23:0], a[15:14]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int fd;
    int i;
    int j;
    string line;

    arst_n = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    cont1_key = '0;
    pix_ce = 1'b0;
    hblank = 1'b0;
    vblank = 1'b0;
    hsync = 1'b0;
    vsync = 1'b0;
    pix_rgb = '0;
    dotclock_divider = '0;

    // read every record first, so the cycle limit is known
    fd = $fopen("core_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open core_testdata.txt for reading");
      $display("Test failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        if (n_rec >= max_records) begin
          $display("core_testdata.txt holds more records than the testbench can store");
          $display("Test failed");
          $fatal(1);
        end
        rec_kind[n_rec] = line.getc(0);
        for (j = 0; j < 6; j++) begin
          rec_f[n_rec][j] = '0;
        end
        void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h",
                      rec_f[n_rec][0], rec_f[n_rec][1], rec_f[n_rec][2],
                      rec_f[n_rec][3], rec_f[n_rec][4], rec_f[n_rec][5]));
        if (rec_kind[n_rec] == "P") begin
          rand_steps += rec_f[n_rec][0];
        end
        n_rec++;
      end
    end
    $fclose(fd);
    cycle_limit = 8 * n_rec + 100 + rand_steps;

    // reset for four cycles
    repeat (4) @(negedge clk_74a);
    arst_n = 1'b1;
    check_settings({border_enable, overscan_enable, sgx_mode, cart_download}, 4'b0000);
    check_buttons(pad_buttons, 8'h00);
    check_video(video_rgb, video_de, video_hs, video_vs, '0, 1'b0, 1'b0, 1'b0);

    for (i = 0; i < n_rec; i++) begin
      case (rec_kind[i])
        "W": bridge_write(rec_f[i][0], rec_f[i][1]);
        "R": bridge_read(rec_f[i][0], rec_f[i][1]);
        "K": key_step(rec_f[i][0][15:0], rec_f[i][1][7:0]);
        "V": pixel_step(1'b1, rec_f[i][0][0], rec_f[i][1][0], rec_f[i][2][0],
                        rec_f[i][3][0], rec_f[i][4][23:0], rec_f[i][5][1:0]);
        "P": random_steps(rec_f[i][0]);
        default: begin
          $display("unknown record kind in core_testdata.txt at record %0d", i);
          $display("Test failed");
          $fatal(1);
        end
      endcase
    end

    $display("Test passed");
    $finish;
  end

endmodule

/* core_testdata.txt */
# W addr data | R addr rd_data | K keys buttons | P random_steps
# V hblank vblank hsync vsync rgb divider (pix_ce high), all hex
R 00000000 00000000
R 00000004 00000000
R 00000100 00000000
R 00000104 00000000
W 00000000 00000001
R 00000000 00000001
W 00000004 00000001
R 00000004 00000001
W 00000100 00000001
R 00000100 00000001
W 00000104 00000001
R 00000104 00000001
W 00000000 00000000
W 00000004 00000000
W 00000100 00000000
W 00000104 00000000
W 00000008 00000001
R 00000008 00000000
K 0001 01
K 0030 30
K c000 c0
K 010c 0c
K 3fc0 00
V 0 0 0 0 123456 0
V 0 0 0 0 abcdef 0
V 1 0 1 0 aaaaaa 0
V 1 0 1 0 555555 0
V 1 0 0 0 555555 0
V 0 0 0 0 0f0f0f 1
V 0 1 0 1 0f0f0f 1
V 0 1 0 1 0f0f0f 1
V 0 0 0 0 204080 2
V 1 0 0 0 204080 2
V 0 0 0 0 fedcba 3
V 1 1 0 0 fedcba 3
V 1 1 0 0 fedcba 3
P 00000200

/* sim.f */
+incdir+.
core_pkg.sv
bridge_settings_regs.sv
pad_key_sync.sv
video_out_conditioner.sv
core_top.sv
tb_core_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the core wrapper testbench with Verilator, runs it and
# looks for the pass message in the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_core_top -f sim.f -o tb_core_top &&
  ./obj_dir/tb_core_top | tee /dev/stderr | grep -q "Test passed" &&
  echo "simulation ok" ||
  { echo "simulation FAILED"; exit 1; }
